/* dbg_cfg.svh */
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// ##################################################
// Debug subsystem configuration

// Clock cycles per serial bit
`define DBG_CLKS_PER_BIT 16

// Instruction memory size in words
`define DBG_IMEM_DEPTH 64

// Most core steps one RUN may take
`define DBG_RUN_LIMIT 1024

`endif

/* core_pkg.sv */
package core_pkg;

	// Data and register width
	typedef logic [15:0] word_t;

	// One of r0 to r3
	typedef logic [1:0] reg_idx_t;

	// Codes not listed behave as NOP
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_LDI  = 4'h1,
		OP_ADD  = 4'h2,
		OP_SUB  = 4'h3,
		OP_XOR  = 4'h4,
		OP_HALT = 4'hf
	} opcode_t;

	// Opcode on top, immediate in the low byte
	typedef struct packed {
		logic [3:0] opcode;
		reg_idx_t   rd;
		reg_idx_t   rs;
		logic [7:0] imm;
	} instr_t;

endpackage

/* dbg_pkg.sv */
package dbg_pkg;

	// Host command bytes
	typedef enum logic [7:0] {
		CMD_LOAD  = 8'h4c,
		CMD_RESET = 8'h43,
		CMD_RUN   = 8'h52,
		CMD_STEP  = 8'h53
	} cmd_t;

	// Single byte answers
	typedef enum logic [7:0] {
		ACK = 8'h06,
		NAK = 8'h15
	} reply_t;

	// Sequencer states of debug_fsm
	typedef enum logic [3:0] {
		ST_IDLE, ST_LOAD_COUNT, ST_LOAD_HI, ST_LOAD_LO,
		ST_STEP, ST_RUN, ST_DUMP_START, ST_DUMP_SEND, ST_DUMP_WAIT,
		ST_REPLY, ST_REPLY_WAIT
	} dbg_state_t;

endpackage

/* baud_timer.sv */
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module baud_timer (
	input  logic clk,
	input  logic reset,
	input  logic restart,
	output logic tick,
	output logic half
);
	localparam int CW = $clog2(`DBG_CLKS_PER_BIT);

	logic [CW-1:0] count;

	// Free running modulo counter, realigned by restart
	always_ff @(posedge clk) begin
		if (reset || restart) begin
			count <= '0;
		end else if (tick) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	assign tick = (count == CW'(`DBG_CLKS_PER_BIT - 1));
	assign half = (count == CW'(`DBG_CLKS_PER_BIT / 2 - 1));

endmodule

/* uart_link.sv */
`timescale 1ns/100ps

module uart_link (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic       tx,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx_busy,
	output logic       tx_done,
	output logic [7:0] rx_data,
	output logic       rx_done
);
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t rx_state;
	logic [1:0] rx_sync;
	logic [2:0] rx_bit;
	logic rx_restart;
	logic rx_half;
	logic [9:0] tx_shift;
	logic [3:0] tx_left;
	logic tx_load;
	logic tx_tick;

	// ##################################################
	// Receiver

	// Line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], rx};
		end
	end

	// Start edge puts the timer at bit start
	assign rx_restart = (rx_state == RX_IDLE) && !rx_sync[1];

	baud_timer u_rx_timer (.clk, .reset, .restart(rx_restart), .tick(), .half(rx_half));

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_state <= RX_IDLE;
			rx_bit <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (rx_state)
				RX_IDLE: if (!rx_sync[1]) begin
					rx_state <= RX_START;
				end
				// A short glitch is not a start bit
				RX_START: if (rx_half) begin
					rx_bit <= '0;
					rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (rx_half) begin
					rx_data <= {rx_sync[1], rx_data[7:1]};
					rx_bit <= rx_bit + 1'b1;
					if (rx_bit == 3'd7) begin
						rx_state <= RX_STOP;
					end
				end
				RX_STOP: if (rx_half) begin
					rx_done <= rx_sync[1];
					rx_state <= RX_IDLE;
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	// ##################################################
	// Transmitter

	assign tx_load = tx_start && !tx_busy;
	assign tx_busy = (tx_left != 4'd0);
	assign tx = tx_shift[0];

	baud_timer u_tx_timer (.clk, .reset, .restart(tx_load), .tick(tx_tick), .half());

	// Stop, data and start bits, shifted out from bit 0
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_shift <= '1;
			tx_left <= '0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (tx_load) begin
				tx_shift <= {1'b1, tx_data, 1'b0};
				tx_left <= 4'd10;
			end else if (tx_busy && tx_tick) begin
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx_left <= tx_left - 1'b1;
				tx_done <= (tx_left == 4'd1);
			end
		end
	end

	// The sequencer holds off until the previous byte is out
	assert property (@(posedge clk) disable iff (reset) tx_start |-> !tx_busy)
		else $error("uart_link: tx_start while transmitter busy");

endmodule

/* dump_collector.sv */
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module dump_collector (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               dump_start,
	input  logic                               byte_next,
	input  logic [$clog2(`DBG_IMEM_DEPTH)-1:0] pc,
	input  core_pkg::word_t [3:0]              regs,
	output logic [7:0]                         byte_out,
	output logic                               dump_last
);
	logic [$clog2(`DBG_IMEM_DEPTH)-1:0] snap_pc;
	core_pkg::word_t [3:0] snap_regs;
	logic [3:0] idx;
	logic [9:0][7:0] frame;

	// Core state frozen for the whole dump
	always_ff @(posedge clk) begin
		if (dump_start) begin
			snap_pc <= pc;
			snap_regs <= regs;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || dump_start) begin
			idx <= '0;
		end else if (byte_next && !dump_last) begin
			idx <= idx + 1'b1;
		end
	end

	// PC first, then r0 to r3, high bytes leading
	assign frame = {core_pkg::word_t'(snap_pc), snap_regs[0], snap_regs[1],
		snap_regs[2], snap_regs[3]};
	assign byte_out = frame[4'd9 - idx];
	assign dump_last = (idx == 4'd9);

endmodule

/* tiny_core.sv */
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module tiny_core (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               core_clear,
	input  logic                               core_step,
	input  logic                               imem_we,
	input  logic [$clog2(`DBG_IMEM_DEPTH)-1:0] imem_addr,
	input  core_pkg::instr_t                   imem_data,
	output logic [$clog2(`DBG_IMEM_DEPTH)-1:0] pc,
	output core_pkg::word_t [3:0]              regs,
	output logic                               halted
);
	core_pkg::instr_t imem [`DBG_IMEM_DEPTH];
	core_pkg::instr_t ins;
	core_pkg::word_t dst;
	core_pkg::word_t src;

	// ##################################################
	// Instruction memory

	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_data;
		end
	end

	// Asynchronous fetch at the current PC
	assign ins = imem[pc];
	assign dst = regs[ins.rd];
	assign src = regs[ins.rs];

	// ##################################################
	// Execute, one instruction per enabled cycle

	always_ff @(posedge clk) begin
		if (reset || core_clear) begin
			pc <= '0;
			regs <= '0;
			halted <= 1'b0;
		end else if (core_step) begin
			case (core_pkg::opcode_t'(ins.opcode))
				core_pkg::OP_LDI: regs[ins.rd] <= core_pkg::word_t'(ins.imm);
				core_pkg::OP_ADD: regs[ins.rd] <= dst + src;
				core_pkg::OP_SUB: regs[ins.rd] <= dst - src;
				core_pkg::OP_XOR: regs[ins.rd] <= dst ^ src;
				default: ;
			endcase
			// HALT parks the PC on itself
			if (ins.opcode == core_pkg::OP_HALT) begin
				halted <= 1'b1;
			end else begin
				pc <= pc + 1'b1;
			end
		end
	end

	// Loading and stepping are separate debugger phases
	assert property (@(posedge clk) disable iff (reset) !(imem_we && core_step))
		else $error("tiny_core: memory write during a step");

endmodule

/* debug_fsm.sv */
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module debug_fsm (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [7:0]                         rx_data,
	input  logic                               rx_done,
	output logic [7:0]                         tx_data,
	output logic                               tx_start,
	input  logic                               tx_busy,
	input  logic                               tx_done,
	output logic                               imem_we,
	output logic [$clog2(`DBG_IMEM_DEPTH)-1:0] imem_addr,
	output core_pkg::instr_t                   imem_data,
	output logic                               core_clear,
	output logic                               core_step,
	input  logic                               halted,
	output logic                               dump_start,
	output logic                               byte_next,
	input  logic [7:0]                         byte_out,
	input  logic                               dump_last
);
	localparam int RW = $clog2(`DBG_RUN_LIMIT + 1);

	dbg_pkg::dbg_state_t state;
	dbg_pkg::reply_t reply;
	logic [7:0] hi_byte;
	logic [7:0] load_left;
	logic [RW-1:0] run_cnt;
	logic limit_hit;
	logic count_ok;

	assign limit_hit = (run_cnt == RW'(`DBG_RUN_LIMIT));
	assign count_ok = (rx_data != 8'd0) && (rx_data <= 8'(`DBG_IMEM_DEPTH));

	// ##################################################
	// Strobes toward link, core and collector

	assign core_clear = (state == dbg_pkg::ST_IDLE) && rx_done &&
		(rx_data == dbg_pkg::CMD_RESET);
	assign core_step = (state == dbg_pkg::ST_STEP) ||
		((state == dbg_pkg::ST_RUN) && !halted && !limit_hit);
	assign imem_we = (state == dbg_pkg::ST_LOAD_LO) && rx_done;
	assign imem_data = {hi_byte, rx_data};
	assign dump_start = (state == dbg_pkg::ST_DUMP_START);
	assign byte_next = (state == dbg_pkg::ST_DUMP_WAIT) && tx_done && !dump_last;
	assign tx_start = ((state == dbg_pkg::ST_REPLY) || (state == dbg_pkg::ST_DUMP_SEND)) &&
		!tx_busy;
	assign tx_data = (state == dbg_pkg::ST_DUMP_SEND) ? byte_out : reply;

	// ##################################################
	// Command sequencer

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dbg_pkg::ST_IDLE;
			run_cnt <= '0;
			load_left <= '0;
			imem_addr <= '0;
		end else begin
			case (state)
				dbg_pkg::ST_IDLE: if (rx_done) begin
					case (dbg_pkg::cmd_t'(rx_data))
						dbg_pkg::CMD_LOAD: state <= dbg_pkg::ST_LOAD_COUNT;
						dbg_pkg::CMD_RESET: begin
							reply <= dbg_pkg::ACK;
							state <= dbg_pkg::ST_REPLY;
						end
						dbg_pkg::CMD_RUN: begin
							run_cnt <= '0;
							state <= dbg_pkg::ST_RUN;
						end
						// A halted core is only dumped
						dbg_pkg::CMD_STEP: state <= halted ? dbg_pkg::ST_DUMP_START : dbg_pkg::ST_STEP;
						default: begin
							reply <= dbg_pkg::NAK;
							state <= dbg_pkg::ST_REPLY;
						end
					endcase
				end
				dbg_pkg::ST_LOAD_COUNT: if (rx_done) begin
					if (count_ok) begin
						load_left <= rx_data;
						imem_addr <= '0;
						state <= dbg_pkg::ST_LOAD_HI;
					end else begin
						reply <= dbg_pkg::NAK;
						state <= dbg_pkg::ST_REPLY;
					end
				end
				dbg_pkg::ST_LOAD_HI: if (rx_done) begin
					hi_byte <= rx_data;
					state <= dbg_pkg::ST_LOAD_LO;
				end
				// Low byte completes the word and writes it
				dbg_pkg::ST_LOAD_LO: if (rx_done) begin
					imem_addr <= imem_addr + 1'b1;
					load_left <= load_left - 1'b1;
					if (load_left == 8'd1) begin
						reply <= dbg_pkg::ACK;
						state <= dbg_pkg::ST_REPLY;
					end else begin
						state <= dbg_pkg::ST_LOAD_HI;
					end
				end
				dbg_pkg::ST_STEP: state <= dbg_pkg::ST_DUMP_START;
				dbg_pkg::ST_RUN: if (core_step) begin
					run_cnt <= run_cnt + 1'b1;
				end else begin
					state <= dbg_pkg::ST_DUMP_START;
				end
				dbg_pkg::ST_DUMP_START: state <= dbg_pkg::ST_DUMP_SEND;
				dbg_pkg::ST_DUMP_SEND: if (tx_start) begin
					state <= dbg_pkg::ST_DUMP_WAIT;
				end
				dbg_pkg::ST_DUMP_WAIT: if (tx_done) begin
					state <= dump_last ? dbg_pkg::ST_IDLE : dbg_pkg::ST_DUMP_SEND;
				end
				dbg_pkg::ST_REPLY: if (tx_start) begin
					state <= dbg_pkg::ST_REPLY_WAIT;
				end
				dbg_pkg::ST_REPLY_WAIT: if (tx_done) begin
					state <= dbg_pkg::ST_IDLE;
				end
				default: state <= dbg_pkg::ST_IDLE;
			endcase
		end
	end

	// halted seen in IDLE must still hold when the step is issued
	assert property (@(posedge clk) disable iff (reset) !(core_step && halted))
		else $error("debug_fsm: step issued to a halted core");

endmodule

/* dbg_top.sv */
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module dbg_top (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx
);
	logic [7:0] rx_data;
	logic [7:0] tx_data;
	logic [7:0] byte_out;
	logic rx_done;
	logic tx_start;
	logic tx_busy;
	logic tx_done;
	logic imem_we;
	logic [$clog2(`DBG_IMEM_DEPTH)-1:0] imem_addr;
	logic [$clog2(`DBG_IMEM_DEPTH)-1:0] pc;
	core_pkg::instr_t imem_data;
	core_pkg::word_t [3:0] regs;
	logic core_clear;
	logic core_step;
	logic halted;
	logic dump_start;
	logic byte_next;
	logic dump_last;

	// Serial line to byte strobes
	uart_link u_uart_link (
		.clk, .reset, .rx, .tx,
		.tx_start, .tx_data, .tx_busy, .tx_done, .rx_data, .rx_done
	);

	debug_fsm u_debug_fsm (
		.clk, .reset, .rx_data, .rx_done, .tx_data, .tx_start, .tx_busy, .tx_done,
		.imem_we, .imem_addr, .imem_data, .core_clear, .core_step, .halted,
		.dump_start, .byte_next, .byte_out, .dump_last
	);

	dump_collector u_dump_collector (
		.clk, .reset, .dump_start, .byte_next, .pc, .regs, .byte_out, .dump_last
	);

	tiny_core u_tiny_core (
		.clk, .reset, .core_clear, .core_step,
		.imem_we, .imem_addr, .imem_data, .pc, .regs, .halted
	);

endmodule

/* tb_dbg_top.sv */
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module tb_dbg_top;
	localparam int PCW = $clog2(`DBG_IMEM_DEPTH);
	localparam int BIT_NS = `DBG_CLKS_PER_BIT * 40;
	// Worst case bytes of each test in both directions
	localparam int TOTAL_BYTES = 144 + 477 + 155 + 144 + 16;
	localparam longint WATCHDOG_NS =
		longint'(TOTAL_BYTES + 20) * 10 * `DBG_CLKS_PER_BIT * 40 * 2
		+ longint'(`DBG_RUN_LIMIT) * 40;

	logic clk;
	logic reset;
	logic rx;
	logic tx;

	logic [31:0] lfsr_state = 32'hf8f0_b688;
	logic [7:0] rx_q[$];
	core_pkg::instr_t prog[$];
	core_pkg::instr_t model_mem [`DBG_IMEM_DEPTH];
	core_pkg::word_t model_regs [4];
	logic [PCW-1:0] model_pc;
	logic model_halted;

	dbg_top UUT (.clk, .reset, .rx, .tx);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ##################################################
	// Random source and failure exit

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// Opcodes 9 to 11 stand in for unknown codes
	function automatic core_pkg::instr_t random_instr();
		core_pkg::instr_t ins;
		logic [3:0] op;
		op = 4'(rand_bits(3));
		if (op > 4'd4) begin
			op = op + 4'd4;
		end
		ins.opcode = op;
		ins.rd = 2'(rand_bits(2));
		ins.rs = 2'(rand_bits(2));
		ins.imm = 8'(rand_bits(8));
		return ins;
	endfunction

	task automatic report_failure();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("no reply arrived from the DUT before the watchdog expired");
		report_failure();
	end

	// ##################################################
	// Serial line

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			#2;
			rx = frame[i];
			repeat (`DBG_CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	// Replies can start before the command's stop bit ends
	initial begin : capture
		logic [7:0] b;
		int i;
		forever begin
			@(negedge tx);
			#(BIT_NS / 2);
			if (tx !== 1'b0) begin
				$display("start bit on tx did not stay low to its middle");
				report_failure();
			end
			for (i = 0; i < 8; i++) begin
				#(BIT_NS);
				b[i] = tx;
			end
			#(BIT_NS);
			if (tx !== 1'b1) begin
				$display("stop bit on tx was not high");
				report_failure();
			end
			rx_q.push_back(b);
		end
	end

	task automatic get_byte(output logic [7:0] b);
		while (rx_q.size() == 0) begin
			@(posedge clk);
		end
		b = rx_q.pop_front();
	endtask

	// ##################################################
	// Compare tasks

	task automatic check_reply(input dbg_pkg::reply_t exp, input logic [7:0] got);
		if (got !== 8'(exp)) begin
			$display("error: reply expected %h got %h", exp, got);
			report_failure();
		end
	endtask

	task automatic check_word(input core_pkg::word_t exp, input core_pkg::word_t got,
		input string name);
		if (got !== exp) begin
			$display("error: %s expected %h got %h", name, exp, got);
			report_failure();
		end
	endtask

	task automatic check_pc(input logic [PCW-1:0] exp, input core_pkg::word_t got);
		if (got !== core_pkg::word_t'(exp)) begin
			$display("error: pc expected %h got %h", core_pkg::word_t'(exp), got);
			report_failure();
		end
	endtask

	// ##################################################
	// Reference model of the core

	task automatic model_reset();
		model_pc = '0;
		model_halted = 1'b0;
		for (int i = 0; i < 4; i++) begin
			model_regs[i] = '0;
		end
	endtask

	task automatic model_step();
		core_pkg::instr_t ins;
		core_pkg::word_t d;
		core_pkg::word_t s;
		if (!model_halted) begin
			ins = model_mem[model_pc];
			d = model_regs[ins.rd];
			s = model_regs[ins.rs];
			case (ins.opcode)
				core_pkg::OP_LDI: model_regs[ins.rd] = {8'h00, ins.imm};
				core_pkg::OP_ADD: model_regs[ins.rd] = d + s;
				core_pkg::OP_SUB: model_regs[ins.rd] = d - s;
				core_pkg::OP_XOR: model_regs[ins.rd] = d ^ s;
				default: ;
			endcase
			if (ins.opcode == core_pkg::OP_HALT) begin
				model_halted = 1'b1;
			end else begin
				model_pc = model_pc + 1'b1;
			end
		end
	endtask

	// ##################################################
	// Protocol commands

	task automatic build_program(input int n, input bit end_halt);
		core_pkg::instr_t ins;
		prog.delete();
		for (int i = 0; i < n; i++) begin
			ins = random_instr();
			if (end_halt && i == n - 1) begin
				ins.opcode = core_pkg::OP_HALT;
			end
			prog.push_back(ins);
		end
	endtask

	task automatic load_program();
		logic [7:0] b;
		send_byte(dbg_pkg::CMD_LOAD);
		send_byte(8'(prog.size()));
		foreach (prog[i]) begin
			send_byte(prog[i][15:8]);
			send_byte(prog[i][7:0]);
			model_mem[i] = prog[i];
		end
		get_byte(b);
		check_reply(dbg_pkg::ACK, b);
	endtask

	task automatic check_dump();
		logic [7:0] hi;
		logic [7:0] lo;
		get_byte(hi);
		get_byte(lo);
		check_pc(model_pc, {hi, lo});
		for (int i = 0; i < 4; i++) begin
			get_byte(hi);
			get_byte(lo);
			check_word(model_regs[i], {hi, lo}, $sformatf("r%0d", i));
		end
	endtask

	task automatic cmd_reset();
		logic [7:0] b;
		send_byte(dbg_pkg::CMD_RESET);
		model_reset();
		get_byte(b);
		check_reply(dbg_pkg::ACK, b);
	endtask

	task automatic cmd_step();
		send_byte(dbg_pkg::CMD_STEP);
		model_step();
		check_dump();
	endtask

	task automatic cmd_run();
		int n;
		send_byte(dbg_pkg::CMD_RUN);
		n = 0;
		while (!model_halted && n < `DBG_RUN_LIMIT) begin
			model_step();
			n++;
		end
		check_dump();
	endtask

	// ##################################################
	// Test sequence

	initial begin : main
		logic [7:0] b;
		logic [7:0] bad;
		reset = 1'b1;
		rx = 1'b1;
		for (int i = 0; i < `DBG_IMEM_DEPTH; i++) begin
			model_mem[i] = '0;
		end
		model_reset();
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		repeat (4) @(posedge clk);

		// Load, reset and a single step
		build_program(int'(rand_bits(6)) + 1, 1'b0);
		load_program();
		cmd_reset();
		cmd_step();

		// Short program so stepping runs into older words
		build_program(int'(rand_bits(4)) + 1, 1'b0);
		load_program();
		cmd_reset();
		repeat (40) cmd_step();

		// Run until HALT and step the halted core
		build_program(int'(rand_bits(6)) + 1, 1'b1);
		load_program();
		cmd_reset();
		cmd_run();
		cmd_step();

		// Full memory without HALT hits the run limit
		build_program(`DBG_IMEM_DEPTH, 1'b0);
		load_program();
		cmd_reset();
		cmd_run();

		// Unknown command and an empty load
		bad = 8'(rand_bits(8));
		if (bad == dbg_pkg::CMD_LOAD || bad == dbg_pkg::CMD_RESET ||
			bad == dbg_pkg::CMD_RUN || bad == dbg_pkg::CMD_STEP) begin
			bad = bad ^ 8'h80;
		end
		send_byte(bad);
		get_byte(b);
		check_reply(dbg_pkg::NAK, b);
		send_byte(dbg_pkg::CMD_LOAD);
		send_byte(8'h00);
		get_byte(b);
		check_reply(dbg_pkg::NAK, b);
		cmd_step();

		$display("TEST OK");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
core_pkg.sv
dbg_pkg.sv
baud_timer.sv
uart_link.sv
dump_collector.sv
tiny_core.sv
debug_fsm.sv
dbg_top.sv
tb_dbg_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dbg_top
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= TEST OK
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
